/* sim.f */
+incdir+sim
hw/vdp_csr_pkg.sv
hw/vdp_mem_pkg.sv
hw/vdp_csr_regs.sv
hw/vdp_fetch_ctrl.sv
hw/vdp_vector_buf.sv
hw/vdp_dot_tree.sv
hw/vdp_top.sv
sim/tb_vdp.sv

/* sim/tb_vdp_tests.svh */
// ============================================================
// host port access
// ============================================================

task automatic csr_write(input csr_addr_e addr, input logic [63:0] data);
  @(posedge clk_i);
  csr_v_i     <= 1'b1;
  csr_we_i    <= 1'b1;
  csr_addr_i  <= addr;
  csr_wdata_i <= data;
  @(posedge clk_i);
  csr_v_i  <= 1'b0;
  csr_we_i <= 1'b0;
endtask

// response must come exactly one cycle after the strobe.
task automatic csr_read(input csr_addr_e addr, output logic [63:0] data);
  @(posedge clk_i);
  csr_v_i    <= 1'b1;
  csr_we_i   <= 1'b0;
  csr_addr_i <= addr;
  @(posedge clk_i);
  csr_v_i <= 1'b0;
  @(negedge clk_i);
  check(csr_rvalid_o, 1'b1, "csr_rvalid_o");
  data = csr_rdata_o;
  @(negedge clk_i);
  check(csr_rvalid_o, 1'b0, "csr_rvalid_o");
endtask

task automatic csr_expect(input csr_addr_e addr, input logic [63:0] exp, input string name);
  logic [63:0] data;
  csr_read(addr, data);
  check(data, exp, name);
endtask

// ============================================================
// reference model and job helpers
// ============================================================

function automatic logic [63:0] dot_ref(input logic [ADDR_W-1:0] a, b, input int n);
  logic [63:0] acc;
  acc = '0;
  for (int i = 0; i < n; i++) begin
    acc = acc + mem[word_index(a + 8 * i)] * mem[word_index(b + 8 * i)];
  end
  return acc;
endfunction

task automatic fill_vectors(input logic [ADDR_W-1:0] a, b);
  for (int i = 0; i < VEC_LEN_MAX; i++) begin
    mem[word_index(a + 8 * i)] = {$random(seed), $random(seed)};
    mem[word_index(b + 8 * i)] = {$random(seed), $random(seed)};
  end
endtask

task automatic run_job(input logic [ADDR_W-1:0] a, b, res, input int len);
  logic [63:0] status;
  int          polls;
  csr_write(CSR_A_PTR, a);
  csr_write(CSR_B_PTR, b);
  csr_write(CSR_RES_PTR, res);
  csr_write(CSR_LEN, len);
  load_q.delete();
  store_count = 0;
  csr_write(CSR_START, 1);
  polls  = 0;
  status = '0;
  while (status != 1) begin
    csr_read(CSR_STATUS, status);
    polls++;
    if (polls > 300) begin
      $display("job never returned to idle");
      $display("sim failed");
      $fatal(1, "job did not finish");
    end
  end
  check(store_count, 1, "store_count");
  check(last_store_addr, res, "store address");
  csr_expect(CSR_START, 0, "start");
endtask

// ============================================================
// directed tests
// ============================================================

task automatic test_reset_regs();
  csr_expect(CSR_STATUS, 1, "status");
  csr_expect(CSR_A_PTR, 0, "a_ptr");
  csr_expect(CSR_B_PTR, 0, "b_ptr");
  csr_expect(CSR_LEN, 0, "len");
  csr_expect(CSR_START, 0, "start");
  csr_expect(CSR_RES_PTR, 0, "res_ptr");
  csr_write(CSR_A_PTR, 40'hab_cdef_0120);
  csr_write(CSR_B_PTR, 40'h12_3456_7898);
  csr_write(CSR_RES_PTR, 40'hfe_dcba_9870);
  csr_expect(CSR_A_PTR, 40'hab_cdef_0120, "a_ptr");
  csr_expect(CSR_B_PTR, 40'h12_3456_7898, "b_ptr");
  csr_expect(CSR_RES_PTR, 40'hfe_dcba_9870, "res_ptr");
  // lengths above the buffer depth saturate.
  csr_write(CSR_LEN, 13);
  csr_expect(CSR_LEN, 8, "len");
  csr_write(CSR_LEN, 5);
  csr_expect(CSR_LEN, 5, "len");
endtask

task automatic test_full_length();
  logic [63:0] expected;
  fill_vectors(40'h0400, 40'h0800);
  expected = dot_ref(40'h0400, 40'h0800, 8);
  run_job(40'h0400, 40'h0800, 40'h0c00, 8);
  check(load_q.size(), 16, "load count");
  check(mem[word_index(40'h0c00)], expected, "result");
endtask

task automatic test_short_vectors();
  logic [63:0] expected;
  fill_vectors(40'h1000, 40'h1400);
  expected = dot_ref(40'h1000, 40'h1400, 3);
  run_job(40'h1000, 40'h1400, 40'h1800, 3);
  check(load_q.size(), 6, "load count");
  for (int i = 0; i < 3; i++) begin
    check(load_q[i], 40'h1000 + 8 * i, "load address");
    check(load_q[3 + i], 40'h1400 + 8 * i, "load address");
  end
  check(mem[word_index(40'h1800)], expected, "result");
endtask

task automatic test_back_pressure();
  logic [63:0] expected;
  ready_pct   = 15;
  stall_count = 0;
  fill_vectors(40'h0400, 40'h0800);
  expected = dot_ref(40'h0400, 40'h0800, 8);
  run_job(40'h0400, 40'h0800, 40'h0c08, 8);
  check(mem[word_index(40'h0c08)], expected, "result");
  check(stall_count > 20, 1'b1, "stall_count above 20");
  ready_pct = 70;
endtask

task automatic test_zero_and_back_to_back();
  logic [63:0] expected;
  mem[word_index(40'h1c00)] = '1;
  run_job(40'h0400, 40'h0800, 40'h1c00, 0);
  check(load_q.size(), 0, "load count");
  check(mem[word_index(40'h1c00)], 0, "result");
  // stale elements from earlier jobs must not leak in.
  fill_vectors(40'h1000, 40'h1400);
  expected = dot_ref(40'h1000, 40'h1400, 5);
  run_job(40'h1000, 40'h1400, 40'h1c08, 5);
  check(load_q.size(), 10, "load count");
  check(mem[word_index(40'h1c08)], expected, "result");
endtask

/* sim/tb_vdp.sv */
`timescale 1ns/1ps

module tb_vdp;

  import vdp_csr_pkg::*;
  import vdp_mem_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 400;

  logic                  clk_i;
  logic                  reset_i;
  logic                  csr_v_i;
  logic                  csr_we_i;
  csr_addr_e             csr_addr_i;
  logic [CSR_DATA_W-1:0] csr_wdata_i;
  logic [CSR_DATA_W-1:0] csr_rdata_o;
  logic                  csr_rvalid_o;
  logic                  mem_v_o;
  mem_op_e               mem_op_o;
  logic [ADDR_W-1:0]     mem_addr_o;
  logic [WORD_W-1:0]     mem_wdata_o;
  logic                  mem_ready_i;
  logic                  mem_resp_v_i;
  logic [WORD_W-1:0]     mem_rdata_i;

  // memory model, one word per 8 bytes of an 8 KB window.
  logic [WORD_W-1:0] mem [1024];
  integer            seed;
  int                ready_pct;
  logic              taken;
  mem_op_e           taken_op;
  logic [ADDR_W-1:0] taken_addr;
  logic [WORD_W-1:0] taken_wdata;
  logic              resp_pend;
  int                resp_wait;
  logic [WORD_W-1:0] resp_data;
  logic              stalled;
  mem_op_e           stall_op;
  logic [ADDR_W-1:0] stall_addr;
  logic [WORD_W-1:0] stall_wdata;
  int                stall_count;
  int                store_count;
  logic [ADDR_W-1:0] last_store_addr;
  logic [ADDR_W-1:0] load_q [$];

  vdp_top dut0 (.*);

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [9:0] word_index(input logic [ADDR_W-1:0] addr);
    return addr[12:3];
  endfunction

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string name);
    if (actual !== expected) begin
      $display("Error at %0t: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
      $display("sim failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  `include "tb_vdp_tests.svh"

  // ============================================================
  // memory model
  // ============================================================

  // requests are sampled mid-cycle, away from the clock edge.
  always @(negedge clk_i) begin
    if (reset_i) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        check(mem_v_o, 1'b1, "mem_v_o");
        check(mem_op_o, stall_op, "mem_op_o");
        check(mem_addr_o, stall_addr, "mem_addr_o");
        check(mem_wdata_o, stall_wdata, "mem_wdata_o");
      end
      stalled     = mem_v_o && !mem_ready_i;
      stall_op    = mem_op_o;
      stall_addr  = mem_addr_o;
      stall_wdata = mem_wdata_o;
      if (stalled) begin
        stall_count++;
      end
      if (mem_v_o && mem_ready_i) begin
        taken       = 1'b1;
        taken_op    = mem_op_o;
        taken_addr  = mem_addr_o;
        taken_wdata = mem_wdata_o;
        if (mem_op_o == MEM_STORE) begin
          store_count++;
          last_store_addr = mem_addr_o;
        end else begin
          load_q.push_back(mem_addr_o);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    mem_resp_v_i <= 1'b0;
    if (reset_i) begin
      mem_ready_i <= 1'b0;
      taken = 1'b0;
      resp_pend = 1'b0;
    end else begin
      if (taken) begin
        taken     = 1'b0;
        resp_pend = 1'b1;
        resp_wait = $unsigned($random(seed)) % 6;
        resp_data = mem[word_index(taken_addr)];
        if (taken_op == MEM_STORE) begin
          mem[word_index(taken_addr)] = taken_wdata;
        end
      end
      if (resp_pend && resp_wait == 0) begin
        mem_resp_v_i <= 1'b1;
        mem_rdata_i  <= resp_data;
        resp_pend = 1'b0;
      end else if (resp_pend) begin
        resp_wait--;
      end
      mem_ready_i <= ($unsigned($random(seed)) % 100) < ready_pct;
    end
  end

  // ============================================================
  // run control
  // ============================================================

  initial begin
    seed        = 32'hec14;
    ready_pct   = 70;
    reset_i     = 1'b1;
    csr_v_i     = 1'b0;
    csr_we_i    = 1'b0;
    csr_addr_i  = CSR_A_PTR;
    csr_wdata_i = '0;
    mem_ready_i = 1'b0;
    mem_resp_v_i = 1'b0;
    mem_rdata_i = '0;
    taken       = 1'b0;
    resp_pend   = 1'b0;
    stalled     = 1'b0;
    stall_count = 0;
    store_count = 0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 64'h0101_0101_0101_0101 * (i + 1);
    end
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    test_reset_regs();
    test_full_length();
    test_short_vectors();
    test_back_pressure();
    test_zero_and_back_to_back();
    $display("sim passed");
    $finish;
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("run timed out before all tests finished");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* hw/vdp_top.sv */
`timescale 1ns/1ps

module vdp_top (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                csr_v_i,
  input  logic                                csr_we_i,
  input  vdp_csr_pkg::csr_addr_e              csr_addr_i,
  input  logic [vdp_csr_pkg::CSR_DATA_W-1:0]  csr_wdata_i,
  output logic [vdp_csr_pkg::CSR_DATA_W-1:0]  csr_rdata_o,
  output logic                                csr_rvalid_o,
  output logic                                mem_v_o,
  output vdp_mem_pkg::mem_op_e                mem_op_o,
  output logic [vdp_mem_pkg::ADDR_W-1:0]      mem_addr_o,
  output logic [vdp_mem_pkg::WORD_W-1:0]      mem_wdata_o,
  input  logic                                mem_ready_i,
  input  logic                                mem_resp_v_i,
  input  logic [vdp_mem_pkg::WORD_W-1:0]      mem_rdata_i
);

  import vdp_mem_pkg::*;

  logic [ADDR_W-1:0] a_ptr, b_ptr, res_ptr;
  logic [CNT_W-1:0]  len, count_a, count_b;
  logic              start, busy, done;
  logic              buf_clear, buf_wr, buf_sel_b;
  logic              sum_start, sum_v;
  logic [WORD_W-1:0] sum;
  logic [VEC_LEN_MAX-1:0][WORD_W-1:0] vec_a, vec_b;

  vdp_csr_regs regs0 (
    .clk_i, .reset_i, .csr_v_i, .csr_we_i, .csr_addr_i, .csr_wdata_i,
    .busy_i(busy), .done_i(done), .csr_rdata_o, .csr_rvalid_o,
    .a_ptr_o(a_ptr), .b_ptr_o(b_ptr), .res_ptr_o(res_ptr),
    .len_o(len), .start_o(start)
  );

  vdp_fetch_ctrl ctrl0 (
    .clk_i, .reset_i, .start_i(start), .a_ptr_i(a_ptr), .b_ptr_i(b_ptr),
    .res_ptr_i(res_ptr), .len_i(len), .count_a_i(count_a), .count_b_i(count_b),
    .mem_ready_i, .mem_resp_v_i, .sum_v_i(sum_v), .sum_i(sum),
    .mem_v_o, .mem_op_o, .mem_addr_o, .mem_wdata_o,
    .buf_clear_o(buf_clear), .buf_wr_o(buf_wr), .buf_sel_b_o(buf_sel_b),
    .sum_start_o(sum_start), .busy_o(busy), .done_o(done)
  );

  vdp_vector_buf buf0 (
    .clk_i, .reset_i, .clear_i(buf_clear), .wr_i(buf_wr), .sel_b_i(buf_sel_b),
    .wdata_i(mem_rdata_i), .vec_a_o(vec_a), .vec_b_o(vec_b),
    .count_a_o(count_a), .count_b_o(count_b)
  );

  vdp_dot_tree tree0 (
    .clk_i, .reset_i, .start_i(sum_start), .vec_a_i(vec_a), .vec_b_i(vec_b),
    .sum_o(sum), .sum_v_o(sum_v)
  );

endmodule

/* hw/vdp_dot_tree.sv */
`timescale 1ns/1ps

module vdp_dot_tree (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                start_i,
  input  logic [vdp_mem_pkg::VEC_LEN_MAX-1:0][vdp_mem_pkg::WORD_W-1:0] vec_a_i,
  input  logic [vdp_mem_pkg::VEC_LEN_MAX-1:0][vdp_mem_pkg::WORD_W-1:0] vec_b_i,
  output logic [vdp_mem_pkg::WORD_W-1:0]      sum_o,
  output logic                                sum_v_o
);

  import vdp_mem_pkg::*;

  logic [VEC_LEN_MAX-1:0][WORD_W-1:0] prod_r;
  logic [3:0][WORD_W-1:0] sum_l1;
  logic [1:0][WORD_W-1:0] sum_l2;
  logic [WORD_W-1:0]      sum_r;
  logic                   prod_v_r;
  logic                   sum_v_r;

  // stage 1, low half of each product.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < VEC_LEN_MAX; i++) begin
      prod_r[i] <= vec_a_i[i] * vec_b_i[i];
    end
  end

  // pairwise tree, all sums wrap.
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      sum_l1[i] = prod_r[2*i] + prod_r[2*i+1];
    end
    for (int i = 0; i < 2; i++) begin
      sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prod_v_r <= 1'b0;
      sum_v_r  <= 1'b0;
    end else begin
      prod_v_r <= start_i;
      sum_v_r  <= prod_v_r;
    end
    sum_r <= sum_l2[0] + sum_l2[1];
  end

  assign sum_o   = sum_r;
  assign sum_v_o = sum_v_r;

endmodule

/* hw/vdp_vector_buf.sv */
`timescale 1ns/1ps

module vdp_vector_buf (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                clear_i,
  input  logic                                wr_i,
  input  logic                                sel_b_i,
  input  logic [vdp_mem_pkg::WORD_W-1:0]      wdata_i,
  output logic [vdp_mem_pkg::VEC_LEN_MAX-1:0][vdp_mem_pkg::WORD_W-1:0] vec_a_o,
  output logic [vdp_mem_pkg::VEC_LEN_MAX-1:0][vdp_mem_pkg::WORD_W-1:0] vec_b_o,
  output logic [vdp_mem_pkg::CNT_W-1:0]       count_a_o,
  output logic [vdp_mem_pkg::CNT_W-1:0]       count_b_o
);

  import vdp_mem_pkg::*;

  // index 0 holds vector A, index 1 vector B.
  logic [VEC_LEN_MAX-1:0][WORD_W-1:0] vec_r [2];
  logic [CNT_W-1:0]                   cnt_r [2];

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < 2; b++) begin
      if (reset_i || clear_i) begin
        cnt_r[b] <= '0;
      end else if (wr_i && sel_b_i == b[0]) begin
        cnt_r[b] <= cnt_r[b] + 1'b1;
      end
      // unused slots stay zero after a clear.
      for (int i = 0; i < VEC_LEN_MAX; i++) begin
        if (clear_i) begin
          vec_r[b][i] <= '0;
        end else if (wr_i && sel_b_i == b[0] && cnt_r[b] == CNT_W'(i)) begin
          vec_r[b][i] <= wdata_i;
        end
      end
    end
  end

  assign vec_a_o   = vec_r[0];
  assign vec_b_o   = vec_r[1];
  assign count_a_o = cnt_r[0];
  assign count_b_o = cnt_r[1];

  // controller never loads past the buffer depth.
  no_overfill: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_i |-> cnt_r[sel_b_i] < CNT_W'(VEC_LEN_MAX));

endmodule

/* hw/vdp_fetch_ctrl.sv */
`timescale 1ns/1ps

module vdp_fetch_ctrl (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            start_i,
  input  logic [vdp_mem_pkg::ADDR_W-1:0]  a_ptr_i,
  input  logic [vdp_mem_pkg::ADDR_W-1:0]  b_ptr_i,
  input  logic [vdp_mem_pkg::ADDR_W-1:0]  res_ptr_i,
  input  logic [vdp_mem_pkg::CNT_W-1:0]   len_i,
  input  logic [vdp_mem_pkg::CNT_W-1:0]   count_a_i,
  input  logic [vdp_mem_pkg::CNT_W-1:0]   count_b_i,
  input  logic                            mem_ready_i,
  input  logic                            mem_resp_v_i,
  input  logic                            sum_v_i,
  input  logic [vdp_mem_pkg::WORD_W-1:0]  sum_i,
  output logic                            mem_v_o,
  output vdp_mem_pkg::mem_op_e            mem_op_o,
  output logic [vdp_mem_pkg::ADDR_W-1:0]  mem_addr_o,
  output logic [vdp_mem_pkg::WORD_W-1:0]  mem_wdata_o,
  output logic                            buf_clear_o,
  output logic                            buf_wr_o,
  output logic                            buf_sel_b_o,
  output logic                            sum_start_o,
  output logic                            busy_o,
  output logic                            done_o
);

  import vdp_mem_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_REQ,
    LOAD_WAIT,
    SUM_WAIT,
    STORE_REQ,
    STORE_WAIT
  } state_e;

  state_e state_r;
  state_e state_n;
  logic   sel_b_r;
  logic   sel_b_n;
  logic [WORD_W-1:0] sum_r;
  logic [CNT_W-1:0]  active_cnt;
  logic [ADDR_W-1:0] load_base;
  logic              load_due;

  // active vector and its next element.
  assign active_cnt = sel_b_r ? count_b_i : count_a_i;
  assign load_base  = sel_b_r ? b_ptr_i : a_ptr_i;
  assign load_due   = active_cnt < len_i;

  // ============================================================
  // next state
  // ============================================================

  always_comb begin
    state_n     = state_r;
    sel_b_n     = sel_b_r;
    buf_clear_o = 1'b0;
    buf_wr_o    = 1'b0;
    sum_start_o = 1'b0;
    done_o      = 1'b0;
    case (state_r)
      IDLE: begin
        if (start_i) begin
          buf_clear_o = 1'b1;
          sel_b_n     = 1'b0;
          state_n     = LOAD_REQ;
        end
      end
      LOAD_REQ: begin
        if (!load_due) begin
          if (sel_b_r) begin
            // both vectors in the buffers.
            sum_start_o = 1'b1;
            state_n     = SUM_WAIT;
          end else begin
            sel_b_n = 1'b1;
          end
        end else if (mem_ready_i) begin
          state_n = LOAD_WAIT;
        end
      end
      LOAD_WAIT: begin
        if (mem_resp_v_i) begin
          buf_wr_o = 1'b1;
          state_n  = LOAD_REQ;
        end
      end
      SUM_WAIT: begin
        if (sum_v_i) begin
          state_n = STORE_REQ;
        end
      end
      STORE_REQ: begin
        if (mem_ready_i) begin
          state_n = STORE_WAIT;
        end
      end
      STORE_WAIT: begin
        // store acknowledged.
        if (mem_resp_v_i) begin
          done_o  = 1'b1;
          state_n = IDLE;
        end
      end
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      sel_b_r <= 1'b0;
    end else begin
      state_r <= state_n;
      sel_b_r <= sel_b_n;
    end
    if (state_r == SUM_WAIT && sum_v_i) begin
      sum_r <= sum_i;
    end
  end

  // ============================================================
  // memory request
  // ============================================================

  assign mem_v_o     = (state_r == LOAD_REQ && load_due) || state_r == STORE_REQ;
  assign mem_op_o    = (state_r == STORE_REQ) ? MEM_STORE : MEM_LOAD;
  assign mem_addr_o  = (state_r == STORE_REQ) ? res_ptr_i
                     : load_base + ADDR_W'(active_cnt) * ADDR_W'(ELEM_BYTES);
  assign mem_wdata_o = sum_r;
  assign buf_sel_b_o = sel_b_r;
  assign busy_o      = state_r != IDLE;

  // a stalled request keeps its fields until it is taken.
  req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_v_o && !mem_ready_i |=> mem_v_o && $stable(mem_op_o)
      && $stable(mem_addr_o) && $stable(mem_wdata_o));

endmodule

/* hw/vdp_csr_regs.sv */
`timescale 1ns/1ps

module vdp_csr_regs (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                csr_v_i,
  input  logic                                csr_we_i,
  input  vdp_csr_pkg::csr_addr_e              csr_addr_i,
  input  logic [vdp_csr_pkg::CSR_DATA_W-1:0]  csr_wdata_i,
  input  logic                                busy_i,
  input  logic                                done_i,
  output logic [vdp_csr_pkg::CSR_DATA_W-1:0]  csr_rdata_o,
  output logic                                csr_rvalid_o,
  output logic [vdp_mem_pkg::ADDR_W-1:0]      a_ptr_o,
  output logic [vdp_mem_pkg::ADDR_W-1:0]      b_ptr_o,
  output logic [vdp_mem_pkg::ADDR_W-1:0]      res_ptr_o,
  output logic [vdp_mem_pkg::CNT_W-1:0]       len_o,
  output logic                                start_o
);

  import vdp_csr_pkg::*;
  import vdp_mem_pkg::*;

  logic [ADDR_W-1:0] a_ptr_r;
  logic [ADDR_W-1:0] b_ptr_r;
  logic [ADDR_W-1:0] res_ptr_r;
  logic [CNT_W-1:0]  len_r;
  logic              start_r;
  logic              rvalid_r;
  logic [CSR_DATA_W-1:0] rdata_r;
  logic [CSR_DATA_W-1:0] rdata_n;

  // ============================================================
  // write decode
  // ============================================================

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_r   <= '0;
      b_ptr_r   <= '0;
      res_ptr_r <= '0;
      len_r     <= '0;
      start_r   <= 1'b0;
    end else begin
      if (csr_v_i && csr_we_i) begin
        case (csr_addr_i)
          CSR_A_PTR:   a_ptr_r   <= csr_wdata_i[ADDR_W-1:0];
          CSR_B_PTR:   b_ptr_r   <= csr_wdata_i[ADDR_W-1:0];
          CSR_RES_PTR: res_ptr_r <= csr_wdata_i[ADDR_W-1:0];
          CSR_START:   start_r   <= |csr_wdata_i;
          CSR_LEN: begin
            // clamp to the buffer depth.
            if (csr_wdata_i > CSR_DATA_W'(VEC_LEN_MAX)) begin
              len_r <= CNT_W'(VEC_LEN_MAX);
            end else begin
              len_r <= csr_wdata_i[CNT_W-1:0];
            end
          end
          default: ;
        endcase
      end
      // job finished.
      if (done_i) begin
        start_r <= 1'b0;
      end
    end
  end

  // ============================================================
  // read path
  // ============================================================

  always_comb begin
    case (csr_addr_i)
      CSR_A_PTR:   rdata_n = CSR_DATA_W'(a_ptr_r);
      CSR_B_PTR:   rdata_n = CSR_DATA_W'(b_ptr_r);
      CSR_RES_PTR: rdata_n = CSR_DATA_W'(res_ptr_r);
      CSR_LEN:     rdata_n = CSR_DATA_W'(len_r);
      CSR_START:   rdata_n = {{(CSR_DATA_W-1){1'b0}}, start_r};
      CSR_STATUS:  rdata_n = {{(CSR_DATA_W-1){1'b0}}, ~busy_i};
      default:     rdata_n = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_r <= 1'b0;
    end else begin
      rvalid_r <= csr_v_i & ~csr_we_i;
    end
    rdata_r <= rdata_n;
  end

  assign csr_rdata_o  = rdata_r;
  assign csr_rvalid_o = rvalid_r;
  assign a_ptr_o      = a_ptr_r;
  assign b_ptr_o      = b_ptr_r;
  assign res_ptr_o    = res_ptr_r;
  assign len_o        = len_r;
  assign start_o      = start_r;

  // the engine only leaves idle on a start request.
  busy_after_start: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(busy_i) |-> $past(start_o));

endmodule

/* hw/vdp_mem_pkg.sv */
package vdp_mem_pkg;

  // ============================================================
  // memory port
  // ============================================================

  // byte address width.
  localparam int ADDR_W = 40;

  // element and result width.
  localparam int WORD_W = 64;

  // ============================================================
  // vector geometry
  // ============================================================

  localparam int VEC_LEN_MAX = 8;

  // holds 0 through VEC_LEN_MAX.
  localparam int CNT_W = 4;

  // elements are packed words.
  localparam int ELEM_BYTES = 8;

  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

endpackage

/* hw/vdp_csr_pkg.sv */
package vdp_csr_pkg;

  // ============================================================
  // host register port
  // ============================================================

  localparam int CSR_ADDR_W = 3;
  localparam int CSR_DATA_W = 64;

  // register map.
  typedef enum logic [CSR_ADDR_W-1:0] {
    CSR_A_PTR   = 3'd0,
    CSR_B_PTR   = 3'd1,
    CSR_LEN     = 3'd2,
    CSR_START   = 3'd3,
    // read only, 1 when the engine is idle.
    CSR_STATUS  = 3'd4,
    CSR_RES_PTR = 3'd5
  } csr_addr_e;

endpackage
